//--- filelist.f
+incdir+rtl
rtl/dmem_pkg.sv
rtl/cache_port_if.sv
rtl/io_bram.sv
rtl/dcache_wt.sv
rtl/dmem_cache_bridge.sv
rtl/dmem_subsystem.sv
test/tb_dmem_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the dmem subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_dmem_subsystem \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- test/tb_dmem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_config.svh"

module tb_dmem_subsystem;

  localparam int CLK_PERIOD = 100;
  // Upper bound on CPU operations issued over all tests
  localparam int OPS_TOTAL = 360;
  localparam int WATCHDOG_CYCLES = OPS_TOTAL * (`DMEM_MISS_LATENCY + 4) + 1000;

  logic            clk;
  logic            rst_n;
  logic            dmem_ren;
  dmem_pkg::addr_t dmem_raddr;
  logic            dmem_we;
  dmem_pkg::addr_t dmem_waddr;
  dmem_pkg::word_t dmem_wdata;
  dmem_pkg::strb_t dmem_wstrb;
  dmem_pkg::word_t dmem_rdata;
  logic            dmem_stall;

  // Reference contents of both spaces
  dmem_pkg::word_t ref_mem [`DMEM_MEM_WORDS];
  dmem_pkg::word_t ref_io [`DMEM_IO_WORDS];

  // Expected read results, consumed in order by the checker
  dmem_pkg::word_t exp_q [$];
  dmem_pkg::addr_t exp_addr_q [$];
  int              chk_done;
  int              mism_cnt;
  int              fail_cnt;
  int              tests_run;
  int              tests_failed;
  int              errs_seen;

  dmem_subsystem u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_stall (dmem_stall)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Applies a write to the model and returns the word now stored at addr
  function automatic dmem_pkg::word_t ref_access(input logic wr, input dmem_pkg::addr_t addr,
                                                 input dmem_pkg::word_t data,
                                                 input dmem_pkg::strb_t strb);
    int              idx;
    dmem_pkg::word_t cur;
    if (addr[31]) begin
      idx = int'(addr[30:2]) % `DMEM_IO_WORDS;
      cur = ref_io[idx];
    end else begin
      idx = int'(addr[30:2]) % `DMEM_MEM_WORDS;
      cur = ref_mem[idx];
    end
    if (wr) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          cur[8*b +: 8] = data[8*b +: 8];
        end
      end
      if (addr[31]) begin
        ref_io[idx] = cur;
      end else begin
        ref_mem[idx] = cur;
      end
    end
    return cur;
  endfunction

  // CPU side: present one request and hold it while stall is high
  task automatic run_op(input logic wr, input dmem_pkg::addr_t addr, input dmem_pkg::word_t data,
                        input dmem_pkg::strb_t strb, output int stalls);
    dmem_pkg::word_t expected;
    @(posedge clk);
    #1;
    expected = ref_access(wr, addr, data, strb);
    dmem_ren = !wr;
    dmem_we  = wr;
    if (wr) begin
      dmem_waddr = addr;
      dmem_wdata = data;
      dmem_wstrb = strb;
    end else begin
      dmem_raddr = addr;
    end
    // Cached loads complete in the first stall-low cycle
    if (!wr && !addr[31]) begin
      exp_q.push_back(expected);
      exp_addr_q.push_back(addr);
    end
    stalls = 0;
    @(negedge clk);
    while (dmem_stall) begin
      stalls++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    dmem_ren = 1'b0;
    dmem_we  = 1'b0;
    // I/O load data shows up one cycle after the request
    if (!wr && addr[31]) begin
      exp_q.push_back(expected);
      exp_addr_q.push_back(addr);
    end
    if (addr[31] && stalls != 0) begin
      $display("error at %0t: stall raised for I/O access to %h", $time, addr);
      fail_cnt++;
    end
    if (!addr[31] && stalls == 0) begin
      $display("error at %0t: no stall for cached access to %h", $time, addr);
      fail_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    @(posedge clk);
    errs = mism_cnt + fail_cnt;
    tests_run++;
    if (errs == errs_seen) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs - errs_seen);
    end
    errs_seen = errs;
  endtask

  always @(negedge clk) begin
    if (rst_n && !dmem_stall && chk_done < exp_q.size()) begin
      if (dmem_rdata !== exp_q[chk_done]) begin
        $display("error at %0t: read of %h returned %h, expected %h", $time,
                 exp_addr_q[chk_done], dmem_rdata, exp_q[chk_done]);
        mism_cnt++;
      end
      chk_done++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    dmem_pkg::addr_t addr;
    logic            wr;
    int              st;
    int              st_miss;
    int              st_hit;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(43));
    clk        = 1'b0;
    rst_n      = 1'b0;
    dmem_ren   = 1'b0;
    dmem_raddr = '0;
    dmem_we    = 1'b0;
    dmem_waddr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    for (int i = 0; i < `DMEM_MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    for (int i = 0; i < `DMEM_IO_WORDS; i++) begin
      ref_io[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    if (dmem_stall) begin
      $display("error at %0t: stall high after reset with no request", $time);
      fail_cnt++;
    end
    @(posedge clk);
    #1;
    dmem_raddr = 32'h8000_0000;
    dmem_waddr = 32'h8000_0000;
    @(negedge clk);
    if (dmem_stall) begin
      $display("error at %0t: stall high in an idle cycle on the I/O path", $time);
      fail_cnt++;
    end
    end_test("reset and idle");

    // Lines 4 to 7, each first read must pay the miss latency
    for (int i = 0; i < 4; i++) begin
      addr = 32'h10 + 32'(i) * 32'h104;
      run_op(1'b1, addr, $urandom, 4'hF, st);
      run_op(1'b0, addr, '0, '0, st_miss);
      run_op(1'b0, addr, '0, '0, st_hit);
      if (st_miss < st_hit + `DMEM_MISS_LATENCY) begin
        $display("error at %0t: read of %h took %0d stall cycles on miss and %0d on hit",
                 $time, addr, st_miss, st_hit);
        fail_cnt++;
      end
    end
    end_test("cached write and read");

    run_op(1'b1, 32'h40, 32'hA1B2_C3D4, 4'b0011, st);
    run_op(1'b0, 32'h40, '0, '0, st);
    run_op(1'b1, 32'h40, 32'h5566_7788, 4'b1100, st);
    run_op(1'b0, 32'h40, '0, '0, st);
    run_op(1'b1, 32'h10, 32'hDEAD_BEEF, 4'b1000, st);
    run_op(1'b0, 32'h10, '0, '0, st);
    run_op(1'b1, 32'h114, 32'h0BAD_F00D, 4'b0110, st);
    run_op(1'b0, 32'h114, '0, '0, st);
    end_test("byte strobes");

    // Both addresses land on line 0
    for (int i = 0; i < 4; i++) begin
      run_op(1'b1, 32'h300, $urandom, 4'hF, st);
      run_op(1'b0, 32'h300, '0, '0, st);
      run_op(1'b1, 32'h340, $urandom, 4'($urandom % 16), st);
      run_op(1'b0, 32'h340, '0, '0, st);
      run_op(1'b0, 32'h300, '0, '0, st);
    end
    end_test("conflict and write-through");

    run_op(1'b1, 32'h8000_0010, $urandom, 4'hF, st);
    run_op(1'b0, 32'h8000_0010, '0, '0, st);
    run_op(1'b0, 32'h0000_0010, '0, '0, st);
    run_op(1'b1, 32'h8000_0410, $urandom, 4'b0101, st);
    run_op(1'b0, 32'h8000_0010, '0, '0, st);
    run_op(1'b1, 32'h0000_0020, $urandom, 4'hF, st);
    run_op(1'b0, 32'h8000_0020, '0, '0, st);
    end_test("I/O bypass");

    for (int i = 0; i < 300; i++) begin
      addr = {1'($urandom % 2), 31'($urandom) & 31'h0000_30FC};
      wr   = 1'($urandom % 2);
      run_op(wr, addr, $urandom, 4'($urandom % 16), st);
    end
    end_test("random mix");

    if (chk_done != exp_q.size()) begin
      $display("%0d reads were never compared", exp_q.size() - chk_done);
      fail_cnt++;
    end
    $display("tests run %0d, failed %0d, reads checked %0d, errors %0d", tests_run,
             tests_failed, chk_done, mism_cnt + fail_cnt);
    if (mism_cnt + fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/dmem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_subsystem (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            dmem_ren,
  input  dmem_pkg::addr_t dmem_raddr,
  input  logic            dmem_we,
  input  dmem_pkg::addr_t dmem_waddr,
  input  dmem_pkg::word_t dmem_wdata,
  input  dmem_pkg::strb_t dmem_wstrb,
  output dmem_pkg::word_t dmem_rdata,
  output logic            dmem_stall
);

  // Uncached path to the I/O RAM
  logic            io_ren;
  dmem_pkg::addr_t io_raddr;
  dmem_pkg::word_t io_rdata;
  logic            io_wen;
  dmem_pkg::addr_t io_waddr;
  dmem_pkg::word_t io_wdata;
  dmem_pkg::strb_t io_wstrb;

  cache_port_if cache_if (
    .clk(clk)
  );

  dmem_cache_bridge u_bridge (
    .clk        (clk),
    .rst_n      (rst_n),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .io_rdata   (io_rdata),
    .dmem_rdata (dmem_rdata),
    .dmem_stall (dmem_stall),
    .io_ren     (io_ren),
    .io_raddr   (io_raddr),
    .io_wen     (io_wen),
    .io_waddr   (io_waddr),
    .io_wdata   (io_wdata),
    .io_wstrb   (io_wstrb),
    .cache      (cache_if.bridge)
  );

  dcache_wt u_cache (
    .clk   (clk),
    .rst_n (rst_n),
    .port  (cache_if.cache)
  );

  io_bram u_io (
    .clk   (clk),
    .ren   (io_ren),
    .raddr (io_raddr),
    .wen   (io_wen),
    .waddr (io_waddr),
    .wdata (io_wdata),
    .wstrb (io_wstrb),
    .rdata (io_rdata)
  );

endmodule

`default_nettype wire

//--- rtl/dmem_cache_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_config.svh"

module dmem_cache_bridge (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            dmem_ren,
  input  dmem_pkg::addr_t dmem_raddr,
  input  logic            dmem_we,
  input  dmem_pkg::addr_t dmem_waddr,
  input  dmem_pkg::word_t dmem_wdata,
  input  dmem_pkg::strb_t dmem_wstrb,
  input  dmem_pkg::word_t io_rdata,
  output dmem_pkg::word_t dmem_rdata,
  output logic            dmem_stall,
  output logic            io_ren,
  output dmem_pkg::addr_t io_raddr,
  output logic            io_wen,
  output dmem_pkg::addr_t io_waddr,
  output dmem_pkg::word_t io_wdata,
  output dmem_pkg::strb_t io_wstrb,
  cache_port_if.bridge    cache
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READING,
    S_READ_STALLED,
    S_READ_COMPLETE,
    S_WRITE,
    S_WRITE_COMPLETE
  } state_t;

  state_t          state;
  state_t          state_next;
  logic            rd_valid_next;
  logic            io_rd;
  logic            io_wr;
  logic            rd_start;
  logic            wr_start;
  logic            rd_capture;
  logic            io_rd_last;
  logic            rd_held;
  dmem_pkg::word_t rd_data_q;
  dmem_pkg::addr_t rd_addr_q;
  dmem_pkg::addr_t wr_addr_q;
  dmem_pkg::word_t wr_data_q;
  dmem_pkg::strb_t wr_strb_q;

  // Top address bit selects I/O space
  assign io_rd = dmem_raddr[`DMEM_XLEN-1];
  assign io_wr = dmem_waddr[`DMEM_XLEN-1];

  assign rd_start   = (state == S_IDLE) && dmem_ren && !io_rd;
  assign wr_start   = (state == S_IDLE) && dmem_we && !io_wr;
  assign rd_capture = ((state == S_READING) || (state == S_READ_STALLED)) &&
                      cache.rd_data_valid;

  always_comb begin
    state_next    = state;
    rd_valid_next = cache.rd_valid && !cache.rd_ready;
    case (state)
      S_IDLE: begin
        if (rd_start) begin
          state_next    = S_READING;
          rd_valid_next = 1'b1;
        end else if (wr_start) begin
          state_next = S_WRITE;
        end
      end
      S_READING: begin
        state_next = cache.rd_data_valid ? S_READ_COMPLETE : S_READ_STALLED;
      end
      S_READ_STALLED: begin
        if (cache.rd_data_valid) begin
          state_next = S_READ_COMPLETE;
        end
      end
      S_WRITE: begin
        if (cache.wr_ready) begin
          state_next = S_WRITE_COMPLETE;
        end
      end
      default: begin
        state_next = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= S_IDLE;
      cache.rd_valid <= 1'b0;
    end else begin
      state          <= state_next;
      cache.rd_valid <= rd_valid_next;
    end
  end

  // Cached request is registered when it starts and drives the cache port
  always_ff @(posedge clk) begin
    if (rd_start) begin
      rd_addr_q <= dmem_raddr;
    end
    if (wr_start) begin
      wr_addr_q <= dmem_waddr;
      wr_data_q <= dmem_wdata;
      wr_strb_q <= dmem_wstrb;
    end
    if (rd_capture) begin
      rd_data_q <= cache.rd_data;
    end
  end

  // Loaded word stays on dmem_rdata until the CPU sees stall low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_held <= 1'b0;
    end else if (rd_capture) begin
      rd_held <= 1'b1;
    end else if (!dmem_stall) begin
      rd_held <= 1'b0;
    end
  end

  // Remembers which space the last read went to
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      io_rd_last <= 1'b0;
    end else if (state == S_IDLE && dmem_ren) begin
      io_rd_last <= io_rd;
    end
  end

  assign cache.rd_addr  = rd_addr_q;
  assign cache.wr_valid = (state == S_WRITE);
  assign cache.wr_addr  = wr_addr_q;
  assign cache.wr_data  = wr_data_q;
  assign cache.wr_strb  = wr_strb_q;

  // I/O requests bypass the FSM entirely
  assign io_ren   = dmem_ren && io_rd;
  assign io_raddr = dmem_raddr;
  assign io_wen   = dmem_we && io_wr;
  assign io_waddr = dmem_waddr;
  assign io_wdata = dmem_wdata;
  assign io_wstrb = dmem_wstrb;

  always_comb begin
    if (io_rd_last) begin
      dmem_rdata = io_rdata;
    end else if (rd_held) begin
      dmem_rdata = rd_data_q;
    end else begin
      dmem_rdata = cache.rd_data;
    end
  end

  // Completion states release the CPU
  assign dmem_stall = rd_start || wr_start || (state == S_READING) ||
                      (state == S_READ_STALLED) || (state == S_WRITE);

  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cache.rd_valid && !cache.rd_ready |=> cache.rd_valid && $stable(cache.rd_addr));

  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cache.wr_valid && !cache.wr_ready |=>
      cache.wr_valid && $stable(cache.wr_addr) && $stable(cache.wr_data) &&
      $stable(cache.wr_strb));

  a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_ren && dmem_we));

endmodule

`default_nettype wire

//--- rtl/dcache_wt.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_config.svh"

module dcache_wt (
  input logic         clk,
  input logic         rst_n,
  cache_port_if.cache port
);

  localparam int LINES  = `DMEM_CACHE_LINES;
  localparam int MEM_AW = $bits(dmem_pkg::mem_idx_t);
  localparam int LINE_W = $bits(dmem_pkg::line_idx_t);
  localparam int TAG_W  = $bits(dmem_pkg::tag_t);
  localparam int CNT_W  = $clog2(`DMEM_MISS_LATENCY + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_MISS,
    S_WR_ACK
  } state_t;

  state_t               state;
  logic [LINES-1:0]     line_valid;
  dmem_pkg::tag_t       line_tag [LINES];
  dmem_pkg::word_t      line_data [LINES];
  dmem_pkg::word_t      main_mem [`DMEM_MEM_WORDS];
  logic [CNT_W-1:0]     miss_cnt;
  dmem_pkg::mem_idx_t   miss_idx;
  logic                 rd_pending;
  logic                 rd_accept;
  logic                 rd_hit;
  logic                 wr_hit;
  logic                 fill;
  dmem_pkg::mem_idx_t   rd_idx;
  dmem_pkg::mem_idx_t   wr_idx;
  dmem_pkg::line_idx_t  rd_line;
  dmem_pkg::line_idx_t  wr_line;
  dmem_pkg::line_idx_t  miss_line;
  dmem_pkg::tag_t       rd_tag;
  dmem_pkg::tag_t       wr_tag;
  dmem_pkg::tag_t       miss_tag;

  initial begin
    for (int i = 0; i < `DMEM_MEM_WORDS; i++) begin
      main_mem[i] = '0;
    end
  end

  // Word index splits into tag above line index
  assign rd_idx    = port.rd_addr[2 +: MEM_AW];
  assign wr_idx    = port.wr_addr[2 +: MEM_AW];
  assign rd_line   = rd_idx[LINE_W-1:0];
  assign wr_line   = wr_idx[LINE_W-1:0];
  assign miss_line = miss_idx[LINE_W-1:0];
  assign rd_tag    = rd_idx[MEM_AW-1 -: TAG_W];
  assign wr_tag    = wr_idx[MEM_AW-1 -: TAG_W];
  assign miss_tag  = miss_idx[MEM_AW-1 -: TAG_W];

  assign rd_hit = line_valid[rd_line] && (line_tag[rd_line] == rd_tag);
  assign wr_hit = line_valid[wr_line] && (line_tag[wr_line] == wr_tag);

  // One read in flight at a time
  assign port.rd_ready = (state == S_IDLE) && !rd_pending;
  assign port.wr_ready = (state == S_WR_ACK);
  assign rd_accept     = port.rd_valid && port.rd_ready;
  assign fill          = (state == S_MISS) && (miss_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state              <= S_IDLE;
      miss_cnt           <= '0;
      line_valid         <= '0;
      port.rd_data_valid <= 1'b0;
    end else begin
      port.rd_data_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (rd_accept) begin
            if (rd_hit) begin
              port.rd_data_valid <= 1'b1;
            end else begin
              state    <= S_MISS;
              miss_cnt <= CNT_W'(`DMEM_MISS_LATENCY - 1);
            end
          end else if (port.wr_valid) begin
            state <= S_WR_ACK;
          end
        end
        S_MISS: begin
          if (fill) begin
            state                 <= S_IDLE;
            line_valid[miss_line] <= 1'b1;
            port.rd_data_valid    <= 1'b1;
          end else begin
            miss_cnt <= miss_cnt - 1'b1;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
    end else if (rd_accept) begin
      rd_pending <= 1'b1;
    end else if (port.rd_data_valid) begin
      rd_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      miss_idx     <= rd_idx;
      port.rd_data <= line_data[rd_line];
    end
    if (fill) begin
      port.rd_data         <= main_mem[miss_idx];
      line_tag[miss_line]  <= miss_tag;
      line_data[miss_line] <= main_mem[miss_idx];
    end
    // Write-through, a missing line is not allocated
    if (state == S_WR_ACK) begin
      main_mem[wr_idx] <= dmem_pkg::merge_strb(main_mem[wr_idx], port.wr_data, port.wr_strb);
      if (wr_hit) begin
        line_data[wr_line] <= dmem_pkg::merge_strb(line_data[wr_line], port.wr_data,
                                                   port.wr_strb);
      end
    end
  end

  a_resp_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(port.rd_data_valid && port.wr_ready));

  a_resp_pending: assert property (@(posedge clk) disable iff (!rst_n)
    port.rd_data_valid |-> rd_pending);

endmodule

`default_nettype wire

//--- rtl/io_bram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_config.svh"

module io_bram (
  input  logic            clk,
  input  logic            ren,
  input  dmem_pkg::addr_t raddr,
  input  logic            wen,
  input  dmem_pkg::addr_t waddr,
  input  dmem_pkg::word_t wdata,
  input  dmem_pkg::strb_t wstrb,
  output dmem_pkg::word_t rdata
);

  localparam int AW = $bits(dmem_pkg::io_idx_t);

  dmem_pkg::word_t   mem [`DMEM_IO_WORDS];
  dmem_pkg::io_idx_t ridx;
  dmem_pkg::io_idx_t widx;

  initial begin
    for (int i = 0; i < `DMEM_IO_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Upper address bits are ignored, so the space wraps
  assign ridx = raddr[2 +: AW];
  assign widx = waddr[2 +: AW];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[widx] <= dmem_pkg::merge_strb(mem[widx], wdata, wstrb);
    end
  end

  // Read before write on a shared address
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[ridx];
    end
  end

endmodule

`default_nettype wire

//--- rtl/cache_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_port_if (
  input logic clk
);

  // Read request and response
  logic            rd_valid;
  dmem_pkg::addr_t rd_addr;
  logic            rd_ready;
  dmem_pkg::word_t rd_data;
  logic            rd_data_valid;

  // Write request and response
  logic            wr_valid;
  dmem_pkg::addr_t wr_addr;
  dmem_pkg::word_t wr_data;
  dmem_pkg::strb_t wr_strb;
  logic            wr_ready;

  modport bridge (
    input  clk,
    output rd_valid, rd_addr, wr_valid, wr_addr, wr_data, wr_strb,
    input  rd_ready, rd_data, rd_data_valid, wr_ready
  );

  modport cache (
    input  clk,
    input  rd_valid, rd_addr, wr_valid, wr_addr, wr_data, wr_strb,
    output rd_ready, rd_data, rd_data_valid, wr_ready
  );

endinterface

`default_nettype wire

//--- rtl/dmem_pkg.sv
`default_nettype none

`include "dmem_config.svh"

package dmem_pkg;

  typedef logic [`DMEM_XLEN-1:0] word_t;
  typedef logic [`DMEM_XLEN-1:0] addr_t;
  typedef logic [`DMEM_XLEN/8-1:0] strb_t;

  // Word indices, always taken from address bits above bit 1
  typedef logic [$clog2(`DMEM_MEM_WORDS)-1:0] mem_idx_t;
  typedef logic [$clog2(`DMEM_CACHE_LINES)-1:0] line_idx_t;
  typedef logic [$clog2(`DMEM_MEM_WORDS)-$clog2(`DMEM_CACHE_LINES)-1:0] tag_t;
  typedef logic [$clog2(`DMEM_IO_WORDS)-1:0] io_idx_t;

  // Replace the bytes of old_word selected by strb
  function automatic word_t merge_strb(word_t old_word, word_t new_word, strb_t strb);
    word_t merged;
    merged = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- rtl/dmem_config.svh
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// Data and address width
`define DMEM_XLEN 32

// Cached main memory in words, addresses wrap at this size
`define DMEM_MEM_WORDS 1024

// Direct-mapped lines of one word each
`define DMEM_CACHE_LINES 16

// Main-memory cycles spent on a cache miss
`define DMEM_MISS_LATENCY 4

// I/O block RAM in words, addresses wrap at this size
`define DMEM_IO_WORDS 256

`endif
